/* project.f */
hw/wd_pkg.sv
hw/wd_tag_client.sv
hw/wd_period_counter.sv
hw/wd_axil_write_master.sv
hw/axil_watchdog.sv
verification/axil_watchdog_assert.sv
verification/axil_watchdog_tb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP      = axil_watchdog_tb
FILELIST = project.f
BUILD    = obj_dir

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP)

clean:
	rm -rf $(BUILD)

/* verification/axil_watchdog_tb.sv */
`timescale 1ns/10ps

module axil_watchdog_tb
  import wd_pkg::*;
();

  localparam int         PERIOD    = 16;
  localparam axil_addr_t KICK_ADDR = 32'h0f00000;
  localparam tag_node_t  NODE_ID   = 4'h3;
  localparam int         NROWS     = 6;

  // Columns: awready delay, wready delay, bvalid delay, kicks, frame
  // Frame 0 none, 1 soft reset on then off, 2 frame for another node
  string row_name [NROWS] = '{"no_delay", "short_delay", "slow_data", "long_stall",
                              "soft_reset", "other_node"};
  int    row_tab [NROWS][5] = '{'{0, 0, 0, 4, 0}, '{2, 1, 3, 4, 0}, '{1, 6, 2, 3, 0},
                                '{9, 12, 10, 3, 0}, '{0, 1, 0, 2, 1}, '{1, 0, 2, 4, 2}};

  logic       clk;
  logic       tag_clk;
  logic       rst_n;
  logic       tag_data;
  logic [2:0] rdy;
  axil_addr_t awaddr;
  logic [2:0] awprot;
  logic       awvalid;
  axil_data_t wdata;
  axil_strb_t wstrb;
  logic       wvalid;
  logic       bready;

  string      cur_name = "reset";
  int         cur_dly [3] = '{0, 0, 0};
  logic       soft_seq = 1'b0;
  logic       hold_off = 1'b0;
  int         cyc = 0;
  int         rise_cnt = 0;
  int         aw_hs = 0;
  int         w_hs = 0;
  int         b_hs = 0;
  int         prev_rise = 0;
  int         last_bhs = 0;
  logic       prev_valid = 1'b0;
  logic       aw_prev = 1'b0;
  logic       aw_wait = 1'b0;
  logic       w_wait = 1'b0;
  axil_addr_t last_addr;
  axil_data_t last_data;
  int         wait_cnt [3];
  int         wait_tgt [3];

  axil_watchdog #(
    .PERIOD(PERIOD),
    .KICK_ADDR(KICK_ADDR),
    .TAG_NODE_ID(NODE_ID)
  ) uut (
    .clk_i            (clk),
    .rst_n_i          (rst_n),
    .tag_clk_i        (tag_clk),
    .tag_data_i       (tag_data),
    .m_axil_awaddr_o  (awaddr),
    .m_axil_awprot_o  (awprot),
    .m_axil_awvalid_o (awvalid),
    .m_axil_awready_i (rdy[0]),
    .m_axil_wdata_o   (wdata),
    .m_axil_wstrb_o   (wstrb),
    .m_axil_wvalid_o  (wvalid),
    .m_axil_wready_i  (rdy[1]),
    .m_axil_bresp_i   (2'b00),
    .m_axil_bvalid_i  (rdy[2]),
    .m_axil_bready_o  (bready)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  initial
  begin
    tag_clk = 1'b0;
    forever #40 tag_clk = ~tag_clk;
  end

  task automatic fail_run(string msg);
    $display("%s", msg);
    $display("ERRORS FOUND");
    $fatal(1, "simulation stopped");
  endtask

  task automatic compare_addr(string name, axil_addr_t exp, axil_addr_t act);
    if (act !== exp)
      fail_run($sformatf("ERROR %s: awaddr expected %h, actual %h", name, exp, act));
  endtask

  task automatic compare_data(string name, axil_data_t exp, axil_data_t act);
    if (act !== exp)
      fail_run($sformatf("ERROR %s: wdata expected %h, actual %h", name, exp, act));
  endtask

  task automatic compare_strb(string name, axil_strb_t exp, axil_strb_t act);
    if (act !== exp)
      fail_run($sformatf("ERROR %s: wstrb expected %h, actual %h", name, exp, act));
  endtask

  task automatic compare_prot(string name, logic [2:0] exp, logic [2:0] act);
    if (act !== exp)
      fail_run($sformatf("ERROR %s: awprot expected %h, actual %h", name, exp, act));
  endtask

  task automatic compare_interval(string name, int exp, int act);
    if (act != exp)
      fail_run($sformatf("ERROR %s: kick interval expected %0d, actual %0d", name, exp, act));
  endtask

  // Start bit, id MSB first, data bit, then the line returns low
  task automatic send_frame(tag_node_t id, logic data_bit);
    logic [TAG_FRAME_LEN-1:0] frame;
    frame = {1'b1, id, data_bit};
    for (int i = TAG_FRAME_LEN - 1; i >= 0; i--)
    begin
      @(negedge tag_clk);
      tag_data = frame[i];
    end
    @(negedge tag_clk);
    tag_data = 1'b0;
  endtask

  task automatic run_soft_reset();
    soft_seq = 1'b1;
    send_frame(NODE_ID, 1'b1);
    repeat (4) @(negedge clk);
    hold_off = 1'b1;
    repeat (3 * PERIOD) @(negedge clk);
    send_frame(NODE_ID, 1'b0);
    hold_off = 1'b0;
    for (int i = 0; i < 6 && !awvalid; i++)
      @(negedge clk);
    if (!awvalid)
      fail_run("No kick within 6 cycles after the frame that clears the soft reset");
    @(negedge clk);
    soft_seq = 1'b0;
  endtask

  // AXI slave model, each ready counts from the first cycle its valid is seen
  initial
  begin
    logic [2:0] act;
    rdy = 3'b000;
    wait_cnt = '{0, 0, 0};
    forever
    begin
      @(negedge clk);
      act = {bready, wvalid, awvalid};
      for (int i = 0; i < 3; i++)
      begin
        if (!act[i])
        begin
          rdy[i] = 1'b0;
          wait_cnt[i] = 0;
        end
        else
        begin
          if (wait_cnt[i] == 0)
            wait_tgt[i] = cur_dly[i] + int'($urandom % 2);
          rdy[i] = (wait_cnt[i] >= wait_tgt[i]);
          wait_cnt[i]++;
        end
      end
    end
  end

  // Bus monitor sampling on the rising edge
  always @(posedge clk)
  begin
    int exp_cyc;
    cyc++;
    if (rst_n)
    begin
      if (!soft_seq)
      begin
        if ((aw_wait && !awvalid) || (w_wait && !wvalid))
          fail_run($sformatf("In %s a valid dropped before its ready was seen", cur_name));
        if (aw_wait)
          compare_addr(cur_name, last_addr, awaddr);
        if (w_wait)
          compare_data(cur_name, last_data, wdata);
      end
      if (hold_off && awvalid)
        fail_run($sformatf("In %s a write started while the soft reset was held", cur_name));
      if (awvalid && !aw_prev)
      begin
        rise_cnt++;
        compare_addr(cur_name, KICK_ADDR, awaddr);
        compare_data(cur_name, axil_data_t'(1), wdata);
        compare_strb(cur_name, '1, wstrb);
        compare_prot(cur_name, 3'b000, awprot);
        // Later of one period after the last kick and two cycles after its response
        exp_cyc = (prev_rise + PERIOD > last_bhs + 2) ? prev_rise + PERIOD : last_bhs + 2;
        if (prev_valid && !soft_seq)
          compare_interval(cur_name, exp_cyc - prev_rise, cyc - prev_rise);
        prev_rise = cyc;
        prev_valid = 1'b1;
      end
      aw_hs += int'(awvalid && rdy[0]);
      w_hs += int'(wvalid && rdy[1]);
      b_hs += int'(bready && rdy[2]);
      if (bready && rdy[2])
        last_bhs = cyc;
    end
    aw_prev = awvalid;
    aw_wait = awvalid && !rdy[0];
    w_wait = wvalid && !rdy[1];
    last_addr = awaddr;
    last_data = wdata;
  end

  initial
  begin
    int base_rise;
    int base_aw;
    int base_w;
    int base_b;
    void'($urandom(32'h8b97));
    rst_n = 1'b0;
    tag_data = 1'b0;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    for (int r = 0; r < NROWS; r++)
    begin
      cur_name = row_name[r];
      for (int i = 0; i < 3; i++)
        cur_dly[i] = row_tab[r][i];
      base_rise = rise_cnt;
      base_aw = aw_hs;
      base_w = w_hs;
      base_b = b_hs;
      if (row_tab[r][4] == 2)
        send_frame(NODE_ID ^ 4'h5, 1'b1);
      while (rise_cnt - base_rise < row_tab[r][3])
        @(negedge clk);
      if (row_tab[r][4] == 1)
        run_soft_reset();
      // Let the write in flight finish before the next row
      while (awvalid || wvalid || bready)
        @(negedge clk);
      if (row_tab[r][4] != 1 && (aw_hs - base_aw != rise_cnt - base_rise
          || w_hs - base_w != rise_cnt - base_rise || b_hs - base_b != rise_cnt - base_rise))
        fail_run($sformatf("In %s the handshake counts do not match the kicks", cur_name));
    end
    $display("NO ERRORS");
    $finish;
  end

  // Watchdog sized from the table
  initial
  begin
    int limit;
    limit = 20;
    for (int r = 0; r < NROWS; r++)
      limit += row_tab[r][3] * (PERIOD + row_tab[r][0] + row_tab[r][1] + row_tab[r][2] + 8)
               + ((row_tab[r][4] != 0) ? 4 * PERIOD + 40 : 0);
    repeat (limit) @(posedge clk);
    fail_run($sformatf("Timeout after %0d clock cycles, the test sequence did not complete",
                       limit));
  end

endmodule

/* verification/axil_watchdog_assert.sv */
`timescale 1ns/10ps

module axil_watchdog_assert
  import wd_pkg::*;
(
  input  logic       clk_i
  , input  logic       rst_n_i
  , input  wr_state_e  state_i
  , input  axil_addr_t awaddr_i
  , input  logic       awvalid_i
  , input  logic       awready_i
  , input  axil_data_t wdata_i
  , input  logic       wvalid_i
  , input  logic       wready_i
  , input  logic       bvalid_i
  , input  logic       bready_i
);

  logic aw_seen_q;
  logic w_seen_q;

  // Handshakes seen on the bus for the write in progress
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      aw_seen_q <= 1'b0;
      w_seen_q  <= 1'b0;
    end
    else if (bready_i && bvalid_i)
    begin
      aw_seen_q <= 1'b0;
      w_seen_q  <= 1'b0;
    end
    else
    begin
      aw_seen_q <= aw_seen_q || (awvalid_i && awready_i);
      w_seen_q  <= w_seen_q || (wvalid_i && wready_i);
    end
  end

  // Address and data hold until accepted
  aw_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    awvalid_i && !awready_i |=> awvalid_i && $stable(awaddr_i))
    else $error("awvalid or awaddr changed before awready");

  w_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wvalid_i && !wready_i |=> wvalid_i && $stable(wdata_i))
    else $error("wvalid or wdata changed before wready");

  // Response taken only in RESP after both channels have handshaken
  b_only_resp: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    bready_i |-> state_i == RESP && aw_seen_q && w_seen_q)
    else $error("bready high before the address and data handshakes");

  // No new address until the response of the last write
  no_aw_in_resp: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    aw_seen_q |-> !awvalid_i)
    else $error("awvalid high while waiting for the response");

endmodule

bind wd_axil_write_master axil_watchdog_assert u_protocol_check (
  .clk_i     (clk_i),
  .rst_n_i   (rst_n_i),
  .state_i   (state_q),
  .awaddr_i  (m_axil_awaddr_o),
  .awvalid_i (m_axil_awvalid_o),
  .awready_i (m_axil_awready_i),
  .wdata_i   (m_axil_wdata_o),
  .wvalid_i  (m_axil_wvalid_o),
  .wready_i  (m_axil_wready_i),
  .bvalid_i  (m_axil_bvalid_i),
  .bready_i  (m_axil_bready_o)
);

/* hw/axil_watchdog.sv */
`timescale 1ns/10ps

module axil_watchdog
  import wd_pkg::*;
#(
  parameter int unsigned PERIOD      = 25000000
  , parameter axil_addr_t  KICK_ADDR   = 32'h0f00000
  , parameter tag_node_t   TAG_NODE_ID = 4'h3
)
(
  input  logic         clk_i
  , input  logic         rst_n_i
  , input  logic         tag_clk_i
  , input  logic         tag_data_i
  , output axil_addr_t   m_axil_awaddr_o
  , output logic [2:0]   m_axil_awprot_o
  , output logic         m_axil_awvalid_o
  , input  logic         m_axil_awready_i
  , output axil_data_t   m_axil_wdata_o
  , output axil_strb_t   m_axil_wstrb_o
  , output logic         m_axil_wvalid_o
  , input  logic         m_axil_wready_i
  , input  logic [1:0]   m_axil_bresp_i
  , input  logic         m_axil_bvalid_i
  , output logic         m_axil_bready_o
);

  logic soft_rst;
  logic core_rst_n;
  logic kick_req;
  logic req_ready;

  wd_tag_client #(
    .TAG_NODE_ID(TAG_NODE_ID)
  ) u_tag_client (
    .tag_clk_i  (tag_clk_i),
    .tag_data_i (tag_data_i),
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .soft_rst_o (soft_rst)
  );

  // Core held in reset by either the pin or the tag bit
  assign core_rst_n = rst_n_i && !soft_rst;

  wd_period_counter #(
    .PERIOD(PERIOD)
  ) u_period_counter (
    .clk_i       (clk_i),
    .rst_n_i     (core_rst_n),
    .req_ready_i (req_ready),
    .kick_req_o  (kick_req)
  );

  wd_axil_write_master #(
    .KICK_ADDR(KICK_ADDR)
  ) u_write_master (
    .clk_i            (clk_i),
    .rst_n_i          (core_rst_n),
    .req_i            (kick_req),
    .req_ready_o      (req_ready),
    .m_axil_awaddr_o  (m_axil_awaddr_o),
    .m_axil_awprot_o  (m_axil_awprot_o),
    .m_axil_awvalid_o (m_axil_awvalid_o),
    .m_axil_awready_i (m_axil_awready_i),
    .m_axil_wdata_o   (m_axil_wdata_o),
    .m_axil_wstrb_o   (m_axil_wstrb_o),
    .m_axil_wvalid_o  (m_axil_wvalid_o),
    .m_axil_wready_i  (m_axil_wready_i),
    .m_axil_bresp_i   (m_axil_bresp_i),
    .m_axil_bvalid_i  (m_axil_bvalid_i),
    .m_axil_bready_o  (m_axil_bready_o)
  );

endmodule

/* hw/wd_axil_write_master.sv */
`timescale 1ns/10ps

module wd_axil_write_master
  import wd_pkg::*;
#(
  parameter axil_addr_t KICK_ADDR = 32'h0f00000
)
(
  input  logic         clk_i
  , input  logic         rst_n_i
  , input  logic         req_i
  , output logic         req_ready_o
  , output axil_addr_t   m_axil_awaddr_o
  , output logic [2:0]   m_axil_awprot_o
  , output logic         m_axil_awvalid_o
  , input  logic         m_axil_awready_i
  , output axil_data_t   m_axil_wdata_o
  , output axil_strb_t   m_axil_wstrb_o
  , output logic         m_axil_wvalid_o
  , input  logic         m_axil_wready_i
  , input  logic [1:0]   m_axil_bresp_i
  , input  logic         m_axil_bvalid_i
  , output logic         m_axil_bready_o
);

  wr_state_e state_q;
  wr_state_e state_d;
  logic      aw_done_q;
  logic      aw_done_d;
  logic      w_done_q;
  logic      w_done_d;
  logic      aw_fire;
  logic      w_fire;

  // Fixed kick payload
  assign m_axil_awaddr_o = KICK_ADDR;
  assign m_axil_awprot_o = 3'b000;
  assign m_axil_wdata_o  = axil_data_t'(1);
  assign m_axil_wstrb_o  = '1;

  assign req_ready_o      = (state_q == IDLE);
  assign m_axil_awvalid_o = (state_q == ADDR_DATA) && !aw_done_q;
  assign m_axil_wvalid_o  = (state_q == ADDR_DATA) && !w_done_q;
  assign m_axil_bready_o  = (state_q == RESP);

  assign aw_fire = m_axil_awvalid_o && m_axil_awready_i;
  assign w_fire  = m_axil_wvalid_o && m_axil_wready_i;

  always_comb
  begin
    state_d   = state_q;
    aw_done_d = aw_done_q;
    w_done_d  = w_done_q;
    case (state_q)
      IDLE:
      begin
        if (req_i)
        begin
          state_d   = ADDR_DATA;
          aw_done_d = 1'b0;
          w_done_d  = 1'b0;
        end
      end
      ADDR_DATA:
      begin
        // Address and data may finish in either order
        aw_done_d = aw_done_q || aw_fire;
        w_done_d  = w_done_q || w_fire;
        if (aw_done_d && w_done_d)
        begin
          state_d = RESP;
        end
      end
      RESP:
      begin
        // m_axil_bresp_i is taken with the beat but never acted on
        if (m_axil_bvalid_i)
        begin
          state_d = IDLE;
        end
      end
      default:
      begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      state_q   <= IDLE;
      aw_done_q <= 1'b0;
      w_done_q  <= 1'b0;
    end
    else
    begin
      state_q   <= state_d;
      aw_done_q <= aw_done_d;
      w_done_q  <= w_done_d;
    end
  end

endmodule

/* hw/wd_period_counter.sv */
`timescale 1ns/10ps

module wd_period_counter
#(
  parameter int unsigned PERIOD = 25000000
)
(
  input  logic clk_i
  , input  logic rst_n_i
  , input  logic req_ready_i
  , output logic kick_req_o
);

  localparam int unsigned CNT_W = (PERIOD > 1) ? $clog2(PERIOD) : 1;
  localparam logic [CNT_W-1:0] LAST = CNT_W'(PERIOD - 1);

  logic [CNT_W-1:0] cnt_q;
  logic             advance;

  // A kick is due whenever the count sits at zero
  assign kick_req_o = (cnt_q == '0);

  // Hold at zero until the master takes the request
  assign advance = !kick_req_o || req_ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      cnt_q <= '0;
    end
    else if (advance)
    begin
      if (cnt_q == LAST)
      begin
        cnt_q <= '0;
      end
      else
      begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

endmodule

/* hw/wd_tag_client.sv */
`timescale 1ns/10ps

module wd_tag_client
  import wd_pkg::*;
#(
  parameter tag_node_t TAG_NODE_ID = 4'h3
)
(
  input  logic tag_clk_i
  , input  logic tag_data_i
  , input  logic clk_i
  , input  logic rst_n_i
  , output logic soft_rst_o
);

  localparam int unsigned CNT_W = $clog2(TAG_FRAME_LEN);
  // Position of the data bit once the start bit is consumed
  localparam logic [CNT_W-1:0] DATA_POS = CNT_W'(TAG_FRAME_LEN - 2);

  logic             busy_q;
  logic [CNT_W-1:0] bit_cnt_q;
  tag_node_t        id_q;
  logic             held_q;
  logic             sync_q;

  wire data_bit = busy_q && (bit_cnt_q == DATA_POS);

  // Frame sequencing in the tag clock domain
  always_ff @(posedge tag_clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      busy_q    <= 1'b0;
      bit_cnt_q <= '0;
      held_q    <= 1'b0;
    end
    else if (!busy_q)
    begin
      // Line idles low, a high bit opens a frame
      if (tag_data_i)
      begin
        busy_q    <= 1'b1;
        bit_cnt_q <= '0;
      end
    end
    else if (data_bit)
    begin
      busy_q <= 1'b0;
      // Latch on the same edge the data bit is sampled
      if (id_q == TAG_NODE_ID)
      begin
        held_q <= tag_data_i;
      end
    end
    else
    begin
      bit_cnt_q <= bit_cnt_q + 1'b1;
    end
  end

  // Id shift register
  always_ff @(posedge tag_clk_i)
  begin
    if (busy_q && !data_bit)
    begin
      id_q <= {id_q[TAG_NODE_W-2:0], tag_data_i};
    end
  end

  // Two-flop synchronizer into the core clock
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      sync_q     <= 1'b0;
      soft_rst_o <= 1'b0;
    end
    else
    begin
      sync_q     <= held_q;
      soft_rst_o <= sync_q;
    end
  end

endmodule

/* hw/wd_pkg.sv */
package wd_pkg;

  // AXI4-Lite write side widths
  localparam int unsigned AXIL_ADDR_W = 32;
  localparam int unsigned AXIL_DATA_W = 32;
  localparam int unsigned AXIL_STRB_W = AXIL_DATA_W / 8;

  typedef logic [AXIL_ADDR_W-1:0] axil_addr_t;
  typedef logic [AXIL_DATA_W-1:0] axil_data_t;
  typedef logic [AXIL_STRB_W-1:0] axil_strb_t;

  // Tag frame layout
  // Start bit, then node id MSB first, then one data bit
  localparam int unsigned TAG_NODE_W = 4;
  localparam int unsigned TAG_FRAME_LEN = 1 + TAG_NODE_W + 1;

  typedef logic [TAG_NODE_W-1:0] tag_node_t;

  // Write master FSM
  typedef enum logic [1:0]
  {
    IDLE,
    ADDR_DATA,
    RESP
  } wr_state_e;

endpackage
